// ==== draw_piece.sv ====
`default_nettype none

`include "tetris_consts.svh"

module draw_piece (
  input  logic              pclk,
  input  logic              rst,
  input  video_pkg::count_t hcount_in,
  input  video_pkg::count_t vcount_in,
  input  logic              hsync_in,
  input  logic              vsync_in,
  input  logic              hblnk_in,
  input  logic              vblnk_in,
  input  video_pkg::rgb_t   rgb_in,
  input  piece_pkg::piece_t block,
  input  piece_pkg::rot_t   rot,
  input  piece_pkg::cell_t  xpos,
  input  piece_pkg::cell_t  ypos,
  output video_pkg::count_t hcount_out,
  output video_pkg::count_t vcount_out,
  output logic              hsync_out,
  output logic              vsync_out,
  output logic              hblnk_out,
  output logic              vblnk_out,
  output video_pkg::rgb_t   rgb_out,
  output piece_pkg::cell_t  sq_1_col,
  output piece_pkg::cell_t  sq_1_row,
  output piece_pkg::cell_t  sq_2_col,
  output piece_pkg::cell_t  sq_2_row,
  output piece_pkg::cell_t  sq_3_col,
  output piece_pkg::cell_t  sq_3_row,
  output piece_pkg::cell_t  sq_4_col,
  output piece_pkg::cell_t  sq_4_row
);

  video_pkg::rgb_t   color_light;
  video_pkg::rgb_t   color_dark;
  video_pkg::rgb_t   color_fill;
  video_pkg::rgb_t   rgb_nxt;
  piece_pkg::cell_t  tile_col [4];
  piece_pkg::cell_t  tile_row [4];
  piece_pkg::shade_t shade    [4];

  piece_shape i_piece_shape (
    .block       (block),
    .rot         (rot),
    .xpos        (xpos),
    .ypos        (ypos),
    .sq_1_col    (sq_1_col),
    .sq_1_row    (sq_1_row),
    .sq_2_col    (sq_2_col),
    .sq_2_row    (sq_2_row),
    .sq_3_col    (sq_3_col),
    .sq_3_row    (sq_3_row),
    .sq_4_col    (sq_4_col),
    .sq_4_row    (sq_4_row),
    .color_light (color_light),
    .color_dark  (color_dark),
    .color_fill  (color_fill)
  );

  assign tile_col[0] = sq_1_col;
  assign tile_row[0] = sq_1_row;
  assign tile_col[1] = sq_2_col;
  assign tile_row[1] = sq_2_row;
  assign tile_col[2] = sq_3_col;
  assign tile_row[2] = sq_3_row;
  assign tile_col[3] = sq_4_col;
  assign tile_row[3] = sq_4_row;

  for (genvar i = 0; i < 4; i++) begin : g_tile
    tile_shader i_tile_shader (
      .hcount (hcount_in),
      .vcount (vcount_in),
      .col    (tile_col[i]),
      .row    (tile_row[i]),
      .shade  (shade[i])
    );
  end

  always_comb begin
    rgb_nxt = rgb_in;
    // walk from cell 4 down so cell 1 has the last word on shared edges
    for (int i = 3; i >= 0; i--) begin
      case (shade[i])
        piece_pkg::SHADE_LIGHT: rgb_nxt = color_light;
        piece_pkg::SHADE_DARK:  rgb_nxt = color_dark;
        piece_pkg::SHADE_FILL:  rgb_nxt = color_fill;
        default:                ;
      endcase
    end
    if (hblnk_in || vblnk_in) begin
      rgb_nxt = '0;
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      hcount_out <= '0;
      vcount_out <= '0;
      hsync_out  <= 1'b0;
      vsync_out  <= 1'b0;
      hblnk_out  <= 1'b0;
      vblnk_out  <= 1'b0;
      rgb_out    <= '0;
    end else begin
      hcount_out <= hcount_in;
      vcount_out <= vcount_in;
      hsync_out  <= hsync_in;
      vsync_out  <= vsync_in;
      hblnk_out  <= hblnk_in;
      vblnk_out  <= vblnk_in;
      rgb_out    <= rgb_nxt;
    end
  end

  a_blank_black: assert property (@(posedge pclk) disable iff (rst)
    (hblnk_in || vblnk_in) |=> rgb_out == '0);

  // no tile can start left of the board, so those pixels pass untouched
  a_left_of_board: assert property (@(posedge pclk) disable iff (rst)
    (!hblnk_in && !vblnk_in && hcount_in < 11'(`BOARD_X0)) |=> rgb_out == $past(rgb_in));

endmodule

`default_nettype wire

// ==== piece_pkg.sv ====
`default_nettype none

package piece_pkg;

  // board column or row, sums wrap modulo 32
  typedef logic [4:0] cell_t;

  typedef logic [1:0] rot_t;

  // codes not listed here are invalid pieces
  typedef enum logic [4:0] {
    PIECE_I = 5'd16,
    PIECE_O = 5'd17,
    PIECE_T = 5'd18,
    PIECE_S = 5'd19,
    PIECE_Z = 5'd20,
    PIECE_J = 5'd21,
    PIECE_L = 5'd22
  } piece_t;

  // which part of a tile a pixel falls on
  typedef enum logic [1:0] {
    SHADE_NONE,
    SHADE_LIGHT,
    SHADE_DARK,
    SHADE_FILL
  } shade_t;

endpackage

`default_nettype wire

// ==== piece_shape.sv ====
`default_nettype none

`include "tetris_consts.svh"

module piece_shape (
  input  piece_pkg::piece_t block,
  input  piece_pkg::rot_t   rot,
  input  piece_pkg::cell_t  xpos,
  input  piece_pkg::cell_t  ypos,
  output piece_pkg::cell_t  sq_1_col,
  output piece_pkg::cell_t  sq_1_row,
  output piece_pkg::cell_t  sq_2_col,
  output piece_pkg::cell_t  sq_2_row,
  output piece_pkg::cell_t  sq_3_col,
  output piece_pkg::cell_t  sq_3_row,
  output piece_pkg::cell_t  sq_4_col,
  output piece_pkg::cell_t  sq_4_row,
  output video_pkg::rgb_t   color_light,
  output video_pkg::rgb_t   color_dark,
  output video_pkg::rgb_t   color_fill
);

  // offsets as (col, row) pairs for cells 1..4, element 0 is col of cell 1
  typedef piece_pkg::cell_t [7:0] ofs_t;

  ofs_t ofs;

  function automatic ofs_t mk(input int c1, input int r1, input int c2, input int r2,
                              input int c3, input int r3, input int c4, input int r4);
    ofs_t o;
    o[0] = piece_pkg::cell_t'(c1);
    o[1] = piece_pkg::cell_t'(r1);
    o[2] = piece_pkg::cell_t'(c2);
    o[3] = piece_pkg::cell_t'(r2);
    o[4] = piece_pkg::cell_t'(c3);
    o[5] = piece_pkg::cell_t'(r3);
    o[6] = piece_pkg::cell_t'(c4);
    o[7] = piece_pkg::cell_t'(r4);
    return o;
  endfunction

  always_comb begin
    case (block)
      piece_pkg::PIECE_I: begin
        color_light = `COL_RED_L;
        color_dark  = `COL_RED_D;
        color_fill  = `COL_RED_N;
        ofs = rot[0] ? mk(0, -1, 0, 0, 0, 1, 0, 2) : mk(-1, 0, 0, 0, 1, 0, 2, 0);
      end
      piece_pkg::PIECE_O: begin
        color_light = `COL_YELLOW_L;
        color_dark  = `COL_YELLOW_D;
        color_fill  = `COL_YELLOW_N;
        ofs = mk(0, 0, 1, 0, 0, 1, 1, 1);
      end
      piece_pkg::PIECE_T: begin
        color_light = `COL_PINK_L;
        color_dark  = `COL_PINK_D;
        color_fill  = `COL_PINK_N;
        case (rot)
          2'd0:    ofs = mk(-1, 0, 0, 0, 1, 0, 0, 1);
          2'd1:    ofs = mk(0, -1, 0, 0, -1, 0, 0, 1);
          2'd2:    ofs = mk(-1, 0, 0, 0, 1, 0, 0, -1);
          default: ofs = mk(0, -1, 0, 0, 1, 0, 0, 1);
        endcase
      end
      piece_pkg::PIECE_S: begin
        color_light = `COL_GREEN_L;
        color_dark  = `COL_GREEN_D;
        color_fill  = `COL_GREEN_N;
        ofs = rot[0] ? mk(0, -1, 0, 0, 1, 0, 1, 1) : mk(-1, 1, 0, 0, 0, 1, 1, 0);
      end
      piece_pkg::PIECE_Z: begin
        color_light = `COL_BLUE_L;
        color_dark  = `COL_BLUE_D;
        color_fill  = `COL_BLUE_N;
        ofs = rot[0] ? mk(0, -1, 0, 0, -1, 0, -1, 1) : mk(-1, 0, 0, 0, 0, 1, 1, 1);
      end
      piece_pkg::PIECE_J: begin
        color_light = `COL_CYAN_L;
        color_dark  = `COL_CYAN_D;
        color_fill  = `COL_CYAN_N;
        case (rot)
          2'd0:    ofs = mk(-1, 0, 0, 0, 1, 0, 1, 1);
          2'd1:    ofs = mk(0, -1, 0, 0, 0, 1, 1, -1);
          2'd2:    ofs = mk(-1, -1, -1, 0, 1, 0, 0, 0);
          default: ofs = mk(0, -1, 0, 0, -1, 1, 0, 1);
        endcase
      end
      piece_pkg::PIECE_L: begin
        color_light = `COL_RED_L;
        color_dark  = `COL_RED_D;
        color_fill  = `COL_RED_N;
        case (rot)
          2'd0:    ofs = mk(-1, 0, 0, 0, 1, 0, -1, 1);
          2'd1:    ofs = mk(0, -1, 0, 0, 0, 1, 1, 1);
          2'd2:    ofs = mk(1, -1, -1, 0, 1, 0, 0, 0);
          default: ofs = mk(0, -1, 0, 0, -1, -1, 0, 1);
        endcase
      end
      default: begin
        // unknown code collapses onto the anchor cell
        color_light = `COL_CYAN_L;
        color_dark  = `COL_CYAN_D;
        color_fill  = `COL_CYAN_N;
        ofs = '0;
      end
    endcase
  end

  // 5-bit sums wrap around the board edge
  assign sq_1_col = xpos + ofs[0];
  assign sq_1_row = ypos + ofs[1];
  assign sq_2_col = xpos + ofs[2];
  assign sq_2_row = ypos + ofs[3];
  assign sq_3_col = xpos + ofs[4];
  assign sq_3_row = ypos + ofs[5];
  assign sq_4_col = xpos + ofs[6];
  assign sq_4_row = ypos + ofs[7];

  // a real tetromino never stacks two cells on one board square
  always_comb begin
    assert final (!(block inside {[piece_pkg::PIECE_I:piece_pkg::PIECE_L]}) ||
                  ({sq_1_col, sq_1_row} != {sq_2_col, sq_2_row} &&
                   {sq_1_col, sq_1_row} != {sq_3_col, sq_3_row} &&
                   {sq_1_col, sq_1_row} != {sq_4_col, sq_4_row} &&
                   {sq_2_col, sq_2_row} != {sq_3_col, sq_3_row} &&
                   {sq_2_col, sq_2_row} != {sq_4_col, sq_4_row} &&
                   {sq_3_col, sq_3_row} != {sq_4_col, sq_4_row}))
      else $error("piece %0d rot %0d covers a cell twice", block, rot);
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the draw_piece testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module tb_draw_piece -Mdir obj_dir -o sim_draw_piece; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_draw_piece)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test passed"; then
  exit 0
else
  exit 1
fi

// ==== sim.f ====
+incdir+.
video_pkg.sv
piece_pkg.sv
piece_shape.sv
tile_shader.sv
draw_piece.sv
tb_clock.sv
tb_draw_piece.sv

// ==== tb_clock.sv ====
`default_nettype none

module tb_clock (
  output logic pclk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 2;

  // 4 ns period
  initial begin
    pclk = 1'b0;
    forever #2 pclk = ~pclk;
  end

  // release on a falling edge, like every other input
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge pclk);
    @(negedge pclk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb_draw_piece.sv ====
`default_nettype none

`include "tetris_consts.svh"

module tb_draw_piece;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_TESTS  = 40;
  localparam int NUM_RANDOM = 64;
  // local x and y probed around every tile, hits corners, bevels and neighbours
  localparam int NUM_PROBE = 11;
  localparam int PROBE [NUM_PROBE] = '{-1, 0, 1, 2, 3, 17, 31, 32, 33, 34, 35};
  localparam int PIXELS_PER_TEST = 4 * NUM_PROBE * NUM_PROBE + NUM_RANDOM;
  localparam int TIMEOUT_NS = (NUM_TESTS * PIXELS_PER_TEST + 200) * 4;

  // (col,row) offsets of cells 1..4, one row per piece I..L and rotation 0..3
  localparam int SHAPE [28][8] = '{
    '{-1, 0, 0, 0, 1, 0, 2, 0}, '{0, -1, 0, 0, 0, 1, 0, 2},
    '{-1, 0, 0, 0, 1, 0, 2, 0}, '{0, -1, 0, 0, 0, 1, 0, 2},
    '{0, 0, 1, 0, 0, 1, 1, 1}, '{0, 0, 1, 0, 0, 1, 1, 1},
    '{0, 0, 1, 0, 0, 1, 1, 1}, '{0, 0, 1, 0, 0, 1, 1, 1},
    '{-1, 0, 0, 0, 1, 0, 0, 1}, '{0, -1, 0, 0, -1, 0, 0, 1},
    '{-1, 0, 0, 0, 1, 0, 0, -1}, '{0, -1, 0, 0, 1, 0, 0, 1},
    '{-1, 1, 0, 0, 0, 1, 1, 0}, '{0, -1, 0, 0, 1, 0, 1, 1},
    '{-1, 1, 0, 0, 0, 1, 1, 0}, '{0, -1, 0, 0, 1, 0, 1, 1},
    '{-1, 0, 0, 0, 0, 1, 1, 1}, '{0, -1, 0, 0, -1, 0, -1, 1},
    '{-1, 0, 0, 0, 0, 1, 1, 1}, '{0, -1, 0, 0, -1, 0, -1, 1},
    '{-1, 0, 0, 0, 1, 0, 1, 1}, '{0, -1, 0, 0, 0, 1, 1, -1},
    '{-1, -1, -1, 0, 1, 0, 0, 0}, '{0, -1, 0, 0, -1, 1, 0, 1},
    '{-1, 0, 0, 0, 1, 0, -1, 1}, '{0, -1, 0, 0, 0, 1, 1, 1},
    '{1, -1, -1, 0, 1, 0, 0, 0}, '{0, -1, 0, 0, -1, -1, 0, 1}
  };

  typedef struct packed {
    video_pkg::count_t h;
    video_pkg::count_t v;
    logic              hs;
    logic              vs;
    logic              hb;
    logic              vb;
    video_pkg::rgb_t   rgb;
  } exp_t;

  logic              pclk;
  logic              rst;
  video_pkg::count_t hcount_in;
  video_pkg::count_t vcount_in;
  logic              hsync_in;
  logic              vsync_in;
  logic              hblnk_in;
  logic              vblnk_in;
  video_pkg::rgb_t   rgb_in;
  piece_pkg::piece_t block;
  piece_pkg::rot_t   rot;
  piece_pkg::cell_t  xpos;
  piece_pkg::cell_t  ypos;
  video_pkg::count_t hcount_out;
  video_pkg::count_t vcount_out;
  logic              hsync_out;
  logic              vsync_out;
  logic              hblnk_out;
  logic              vblnk_out;
  video_pkg::rgb_t   rgb_out;
  piece_pkg::cell_t  sq_1_col;
  piece_pkg::cell_t  sq_1_row;
  piece_pkg::cell_t  sq_2_col;
  piece_pkg::cell_t  sq_2_row;
  piece_pkg::cell_t  sq_3_col;
  piece_pkg::cell_t  sq_3_row;
  piece_pkg::cell_t  sq_4_col;
  piece_pkg::cell_t  sq_4_row;

  logic [31:0]     lcg_state;
  int              errors;
  int              checks;
  int              cur_code;
  int              cur_rot;
  int              cur_x;
  int              cur_y;
  int              exp_col [4];
  int              exp_row [4];
  video_pkg::rgb_t pal_light;
  video_pkg::rgb_t pal_dark;
  video_pkg::rgb_t pal_fill;
  exp_t            exp_q [$];

  tb_clock i_tb_clock (
    .pclk (pclk),
    .rst  (rst)
  );

  draw_piece i_draw_piece (
    .pclk       (pclk),
    .rst        (rst),
    .hcount_in  (hcount_in),
    .vcount_in  (vcount_in),
    .hsync_in   (hsync_in),
    .vsync_in   (vsync_in),
    .hblnk_in   (hblnk_in),
    .vblnk_in   (vblnk_in),
    .rgb_in     (rgb_in),
    .block      (block),
    .rot        (rot),
    .xpos       (xpos),
    .ypos       (ypos),
    .hcount_out (hcount_out),
    .vcount_out (vcount_out),
    .hsync_out  (hsync_out),
    .vsync_out  (vsync_out),
    .hblnk_out  (hblnk_out),
    .vblnk_out  (vblnk_out),
    .rgb_out    (rgb_out),
    .sq_1_col   (sq_1_col),
    .sq_1_row   (sq_1_row),
    .sq_2_col   (sq_2_col),
    .sq_2_row   (sq_2_row),
    .sq_3_col   (sq_3_col),
    .sq_3_row   (sq_3_row),
    .sq_4_col   (sq_4_col),
    .sq_4_row   (sq_4_row)
  );

  function automatic int rand_below(input int n);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'({8'd0, lcg_state[31:8]} % 32'(n));
  endfunction

  // cells wrap modulo 32, unknown codes sit on the anchor in cyan
  task automatic load_model(input int code, input int r, input int x, input int y);
    int idx;
    idx = (code - 16) * 4 + r;
    for (int i = 0; i < 4; i++) begin
      if (code >= 16 && code <= 22) begin
        exp_col[i] = (x + SHAPE[idx][2 * i]) & 31;
        exp_row[i] = (y + SHAPE[idx][2 * i + 1]) & 31;
      end else begin
        exp_col[i] = x;
        exp_row[i] = y;
      end
    end
    case (code)
      16, 22: begin
        pal_light = `COL_RED_L;
        pal_dark  = `COL_RED_D;
        pal_fill  = `COL_RED_N;
      end
      17: begin
        pal_light = `COL_YELLOW_L;
        pal_dark  = `COL_YELLOW_D;
        pal_fill  = `COL_YELLOW_N;
      end
      18: begin
        pal_light = `COL_PINK_L;
        pal_dark  = `COL_PINK_D;
        pal_fill  = `COL_PINK_N;
      end
      19: begin
        pal_light = `COL_GREEN_L;
        pal_dark  = `COL_GREEN_D;
        pal_fill  = `COL_GREEN_N;
      end
      20: begin
        pal_light = `COL_BLUE_L;
        pal_dark  = `COL_BLUE_D;
        pal_fill  = `COL_BLUE_N;
      end
      default: begin
        pal_light = `COL_CYAN_L;
        pal_dark  = `COL_CYAN_D;
        pal_fill  = `COL_CYAN_N;
      end
    endcase
  endtask

  function automatic piece_pkg::shade_t shade_of(input int h, input int v, input int c,
                                                 input int r);
    int                x;
    int                y;
    int                last;
    piece_pkg::shade_t res;
    x = h - (`BOARD_X0 + `TILE_SIZE * c);
    y = v - (`BOARD_Y0 + `TILE_SIZE * r);
    last = `TILE_SIZE - 1;
    res = piece_pkg::SHADE_FILL;
    for (int k = 0; k < `BEVEL_W; k++) begin
      if ((x == last - k && y >= k + 1) || (y == last - k && x > k)) begin
        res = piece_pkg::SHADE_DARK;
      end
    end
    // light bevel overrides dark where both rules hit
    for (int k = 0; k < `BEVEL_W; k++) begin
      if ((x == k && y < last - k) || (y == k && x > 0 && x < last - k)) begin
        res = piece_pkg::SHADE_LIGHT;
      end
    end
    if (x < 0 || y < 0 || x > last || y > last) begin
      res = piece_pkg::SHADE_NONE;
    end
    return res;
  endfunction

  function automatic exp_t build_expect();
    exp_t              e;
    piece_pkg::shade_t s;
    logic              found;
    e.h   = hcount_in;
    e.v   = vcount_in;
    e.hs  = hsync_in;
    e.vs  = vsync_in;
    e.hb  = hblnk_in;
    e.vb  = vblnk_in;
    e.rgb = rgb_in;
    found = 1'b0;
    for (int i = 0; i < 4; i++) begin
      s = shade_of(int'(hcount_in), int'(vcount_in), exp_col[i], exp_row[i]);
      if (!found && s != piece_pkg::SHADE_NONE) begin
        found = 1'b1;
        case (s)
          piece_pkg::SHADE_LIGHT: e.rgb = pal_light;
          piece_pkg::SHADE_DARK:  e.rgb = pal_dark;
          default:                e.rgb = pal_fill;
        endcase
      end
    end
    if (hblnk_in || vblnk_in) begin
      e.rgb = '0;
    end
    return e;
  endfunction

  task automatic check_reset_outputs();
    checks++;
    if (hcount_out !== '0 || vcount_out !== '0 || hsync_out !== 1'b0 ||
        vsync_out !== 1'b0 || hblnk_out !== 1'b0 || vblnk_out !== 1'b0 ||
        rgb_out !== '0) begin
      errors++;
      $display("mismatch at %0t: registered outputs not zero under reset", $time);
    end
  endtask

  task automatic check_regs();
    exp_t e;
    if (exp_q.size() > 0) begin
      e = exp_q.pop_front();
      checks++;
      if (hcount_out !== e.h || vcount_out !== e.v || hsync_out !== e.hs ||
          vsync_out !== e.vs || hblnk_out !== e.hb || vblnk_out !== e.vb) begin
        errors++;
        $display("mismatch at %0t: timing h=%0d v=%0d sync=%b%b blank=%b%b exp %0d %0d %b%b %b%b",
                 $time, hcount_out, vcount_out, hsync_out, vsync_out, hblnk_out, vblnk_out,
                 e.h, e.v, e.hs, e.vs, e.hb, e.vb);
      end
      if (rgb_out !== e.rgb) begin
        errors++;
        $display("mismatch at %0t: rgb_out %h expected %h at pixel (%0d,%0d) piece %0d rot %0d",
                 $time, rgb_out, e.rgb, e.h, e.v, cur_code, cur_rot);
      end
    end
  endtask

  task automatic check_cells();
    piece_pkg::cell_t got_col [4];
    piece_pkg::cell_t got_row [4];
    got_col[0] = sq_1_col;
    got_row[0] = sq_1_row;
    got_col[1] = sq_2_col;
    got_row[1] = sq_2_row;
    got_col[2] = sq_3_col;
    got_row[2] = sq_3_row;
    got_col[3] = sq_4_col;
    got_row[3] = sq_4_row;
    for (int i = 0; i < 4; i++) begin
      checks++;
      if (got_col[i] !== 5'(exp_col[i]) || got_row[i] !== 5'(exp_row[i])) begin
        errors++;
        $display("mismatch at %0t: cell %0d at (%0d,%0d) expected (%0d,%0d), piece %0d rot %0d",
                 $time, i + 1, got_col[i], got_row[i], exp_col[i], exp_row[i],
                 cur_code, cur_rot);
      end
    end
  endtask

  // one pixel per falling edge, the previous pixel's result is checked first
  task automatic drive_pixel(input int h, input int v);
    @(negedge pclk);
    check_regs();
    hcount_in = 11'(h);
    vcount_in = 11'(v);
    hsync_in  = 1'(rand_below(2));
    vsync_in  = 1'(rand_below(2));
    hblnk_in  = (rand_below(8) == 0);
    vblnk_in  = (rand_below(8) == 0);
    rgb_in    = 12'(rand_below(4096));
    block     = piece_pkg::piece_t'(5'(cur_code));
    rot       = 2'(cur_rot);
    xpos      = 5'(cur_x);
    ypos      = 5'(cur_y);
    exp_q.push_back(build_expect());
    #1;
    check_cells();
  endtask

  task automatic run_test(input int t);
    if (t < 28) begin
      cur_code = 16 + t / 4;
      cur_rot  = t % 4;
    end else if (t < 32) begin
      cur_code = (t % 2 == 0) ? rand_below(16) : 23 + rand_below(9);
      cur_rot  = rand_below(4);
    end else begin
      cur_code = 16 + rand_below(7);
      cur_rot  = rand_below(4);
    end
    cur_x = 1 + rand_below(8);
    cur_y = 1 + rand_below(10);
    load_model(cur_code, cur_rot, cur_x, cur_y);
    for (int i = 0; i < 4; i++) begin
      for (int py = 0; py < NUM_PROBE; py++) begin
        for (int px = 0; px < NUM_PROBE; px++) begin
          drive_pixel(`BOARD_X0 + `TILE_SIZE * exp_col[i] + PROBE[px],
                      `BOARD_Y0 + `TILE_SIZE * exp_row[i] + PROBE[py]);
        end
      end
    end
    for (int n = 0; n < NUM_RANDOM; n++) begin
      drive_pixel(rand_below(2048), rand_below(2048));
    end
  endtask

  initial begin
    lcg_state = 32'h1c99;
    errors    = 0;
    checks    = 0;
    cur_code  = 16;
    cur_rot   = 0;
    cur_x     = 4;
    cur_y     = 4;
    load_model(cur_code, cur_rot, cur_x, cur_y);
    // nonzero inputs during reset must not reach the outputs
    hcount_in = 11'd100;
    vcount_in = 11'd20;
    hsync_in  = 1'b1;
    vsync_in  = 1'b1;
    hblnk_in  = 1'b1;
    vblnk_in  = 1'b1;
    rgb_in    = 12'h5a5;
    block     = piece_pkg::PIECE_I;
    rot       = 2'd0;
    xpos      = 5'(cur_x);
    ypos      = 5'(cur_y);

    // blank flags high for the first reset edge, low for the second so rgb_in is live
    @(negedge pclk);
    check_reset_outputs();
    hblnk_in = 1'b0;
    vblnk_in = 1'b0;

    wait (rst == 1'b0);
    check_reset_outputs();
    // first edge after release registers the held inputs
    exp_q.push_back(build_expect());

    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    @(negedge pclk);
    check_regs();

    $display("errors: %0d in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("run timed out after %0d ns with %0d errors", TIMEOUT_NS, errors);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tetris_consts.svh ====
`ifndef TETRIS_CONSTS_SVH
`define TETRIS_CONSTS_SVH

// tile geometry in pixels
`define TILE_SIZE 35
`define BEVEL_W   3

// screen position of board cell (0,0)
`define BOARD_X0  201
`define BOARD_Y0  10

// palette, 4 bits per channel r g b
// _L light bevel, _D dark bevel, _N plain fill
`define COL_RED_L    12'hfab
`define COL_RED_D    12'h800
`define COL_RED_N    12'hf00

`define COL_YELLOW_L 12'hff8
`define COL_YELLOW_D 12'hbb6
`define COL_YELLOW_N 12'hff0

`define COL_PINK_L   12'he8e
`define COL_PINK_D   12'h808
`define COL_PINK_N   12'hf0f

`define COL_BLUE_L   12'h0bf
`define COL_BLUE_D   12'h008
`define COL_BLUE_N   12'h00f

`define COL_GREEN_L  12'h9f9
`define COL_GREEN_D  12'h080
`define COL_GREEN_N  12'h0f0

`define COL_CYAN_L   12'hcff
`define COL_CYAN_D   12'h0cf
`define COL_CYAN_N   12'h0ff

`endif

// ==== tile_shader.sv ====
`default_nettype none

`include "tetris_consts.svh"

module tile_shader (
  input  video_pkg::count_t hcount,
  input  video_pkg::count_t vcount,
  input  piece_pkg::cell_t  col,
  input  piece_pkg::cell_t  row,
  output piece_pkg::shade_t shade
);

  localparam logic [11:0] SIZE = 12'(`TILE_SIZE);

  logic [11:0] org_x;
  logic [11:0] org_y;
  logic [11:0] px;
  logic [11:0] py;
  logic [11:0] x;
  logic [11:0] y;
  logic        in_x;
  logic        in_y;
  logic        light;
  logic        dark;

  // 12 bits hold the far corner of cell 31 without overflow
  assign org_x = 12'(`BOARD_X0) + SIZE * 12'(col);
  assign org_y = 12'(`BOARD_Y0) + SIZE * 12'(row);

  assign px = 12'(hcount);
  assign py = 12'(vcount);

  assign in_x = (px >= org_x) && (px < org_x + SIZE);
  assign in_y = (py >= org_y) && (py < org_y + SIZE);

  // local position, only meaningful inside the tile
  assign x = px - org_x;
  assign y = py - org_y;

  always_comb begin
    light = 1'b0;
    dark  = 1'b0;
    for (int k = 0; k < `BEVEL_W; k++) begin
      // top-left bevel stops one pixel short per ring so corners go diagonal
      if (x == 12'(k) && y < SIZE - 12'(k + 1)) begin
        light = 1'b1;
      end
      if (y == 12'(k) && x > 12'd0 && x < SIZE - 12'(k + 1)) begin
        light = 1'b1;
      end
      if (x == SIZE - 12'(k + 1) && y > 12'(k)) begin
        dark = 1'b1;
      end
      if (y == SIZE - 12'(k + 1) && x > 12'(k)) begin
        dark = 1'b1;
      end
    end

    if (!(in_x && in_y)) begin
      shade = piece_pkg::SHADE_NONE;
    end else if (light) begin
      shade = piece_pkg::SHADE_LIGHT;
    end else if (dark) begin
      shade = piece_pkg::SHADE_DARK;
    end else begin
      shade = piece_pkg::SHADE_FILL;
    end
  end

  // board cell recovered by division must be the one this shader owns
  always_comb begin
    assert final (shade == piece_pkg::SHADE_NONE ||
                  (px >= 12'(`BOARD_X0) && py >= 12'(`BOARD_Y0) &&
                   (px - 12'(`BOARD_X0)) / SIZE == 12'(col) &&
                   (py - 12'(`BOARD_Y0)) / SIZE == 12'(row)))
      else $error("shade outside tile at (%0d,%0d)", hcount, vcount);
  end

endmodule

`default_nettype wire

// ==== video_pkg.sv ====
`default_nettype none

package video_pkg;

  // horizontal or vertical pixel position
  typedef logic [10:0] count_t;

  // 4 bits each of red, green, blue
  typedef logic [11:0] rgb_t;

endpackage

`default_nettype wire
